/* flist.f */
tcp_rx_msg_pkg.sv
tcp_rx_msg_req_fifo.sv
tcp_rx_noc_credit_cnt.sv
tcp_rx_msg_noc_if_out_ctrl.sv
tcp_rx_msg_noc_if_out_datap.sv
tcp_rx_msg_noc_if_out.sv
tcp_rx_msg_noc_if_out_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tcp_rx_msg_noc_if_out_tb
FLIST     = flist.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

/* tcp_rx_msg_noc_if_out_tb.sv */
`timescale 1ns/1ps

module tcp_rx_msg_noc_if_out_tb;

    import tcp_rx_msg_pkg::*;

    localparam int src_x = 2;
    localparam int src_y = 5;
    // several times the combined length of the five tests
    localparam int max_cycles = 2000;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        poller_msg_wr;
    logic [flowid_w-1:0]         poller_msg_noc_if_flowid;
    logic [rx_payload_ptr_w:0]   poller_msg_noc_if_head_ptr;
    logic [rx_payload_ptr_w-1:0] poller_msg_noc_if_len;
    logic [xy_w-1:0]             poller_msg_noc_if_dst_x;
    logic [xy_w-1:0]             poller_msg_noc_if_dst_y;
    logic [fbits_w-1:0]          poller_msg_noc_if_dst_fbits;
    logic                        noc_credit_ret;
    logic                        poller_msg_full;
    logic                        noc_val;
    logic [noc_data_w-1:0]       tcp_rx_ptr_if_noc_data;

    poller_msg_t model_q[$];
    integer      seed = 4;
    int          errors = 0;
    int          flit_count = 0;
    int          ret_count = 0;
    int          cycles = 0;

    tcp_rx_msg_noc_if_out #(
        .SRC_X       (src_x),
        .SRC_Y       (src_y),
        .FIFO_DEPTH  (4),
        .NOC_CREDITS (2)
    ) tcp_rx_msg_noc_if_out_i (
        .clk                         (clk),
        .rst                         (rst),
        .poller_msg_wr               (poller_msg_wr),
        .poller_msg_noc_if_flowid    (poller_msg_noc_if_flowid),
        .poller_msg_noc_if_head_ptr  (poller_msg_noc_if_head_ptr),
        .poller_msg_noc_if_len       (poller_msg_noc_if_len),
        .poller_msg_noc_if_dst_x     (poller_msg_noc_if_dst_x),
        .poller_msg_noc_if_dst_y     (poller_msg_noc_if_dst_y),
        .poller_msg_noc_if_dst_fbits (poller_msg_noc_if_dst_fbits),
        .noc_credit_ret              (noc_credit_ret),
        .poller_msg_full             (poller_msg_full),
        .noc_val                     (noc_val),
        .tcp_rx_ptr_if_noc_data      (tcp_rx_ptr_if_noc_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("run stopped after %0d cycles before the tests finished", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flit(input tcp_noc_hdr_flit exp, input tcp_noc_hdr_flit act);
        if (act.core !== exp.core) begin
            $display("** Error at %0t: tcp_rx_ptr_if_noc_data.core expected %h, got %h",
                     $time, exp.core, act.core);
            errors++;
        end
        if (act.inner !== exp.inner) begin
            $display("** Error at %0t: tcp_rx_ptr_if_noc_data.inner expected %h, got %h",
                     $time, exp.inner, act.inner);
            errors++;
        end
        if (act.padding !== exp.padding) begin
            $display("** Error at %0t: tcp_rx_ptr_if_noc_data.padding expected %h, got %h",
                     $time, exp.padding, act.padding);
            errors++;
        end
    endtask

    // header rules of the response flit
    function automatic tcp_noc_hdr_flit expect_flit(input poller_msg_t m);
        tcp_noc_hdr_flit f;
        f = '0;
        f.core.dst_x_coord = m.dst_x;
        f.core.dst_y_coord = m.dst_y;
        f.core.dst_fbits   = m.dst_fbits;
        f.core.msg_type    = 8'h2a;
        f.core.src_x_coord = xy_w'(src_x);
        f.core.src_y_coord = xy_w'(src_y);
        f.core.src_fbits   = 4'h3;
        f.inner.flowid     = m.flowid;
        f.inner.head_ptr   = m.head_ptr;
        f.inner.length     = m.len;
        return f;
    endfunction

    function automatic poller_msg_t random_msg();
        logic [63:0] rnd;
        rnd = {$random(seed), $random(seed)};
        return rnd[$bits(poller_msg_t)-1:0];
    endfunction

    // each send pulse carries the oldest accepted notification
    always @(negedge clk) begin
        if (!rst && noc_val) begin
            flit_count++;
            if (model_q.size() == 0) begin
                $display("flit sent at %0t with no notification pending", $time);
                errors++;
            end else begin
                check_flit(expect_flit(model_q.pop_front()),
                           tcp_noc_hdr_flit'(tcp_rx_ptr_if_noc_data));
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // the queue drops a write seen while full
    task automatic start_write(input poller_msg_t m);
        {poller_msg_noc_if_flowid, poller_msg_noc_if_head_ptr, poller_msg_noc_if_len,
         poller_msg_noc_if_dst_x, poller_msg_noc_if_dst_y, poller_msg_noc_if_dst_fbits} = m;
        poller_msg_wr = 1'b1;
        if (!poller_msg_full) begin
            model_q.push_back(m);
        end
    endtask

    task automatic write_msg(input poller_msg_t m);
        start_write(m);
        next_cycle();
        poller_msg_wr = 1'b0;
    endtask

    task automatic pulse_credit();
        noc_credit_ret = 1'b1;
        ret_count++;
        next_cycle();
        noc_credit_ret = 1'b0;
    endtask

    task automatic drain_and_return();
        while (model_q.size() > 0) begin
            if (flit_count > ret_count) begin
                pulse_credit();
            end else begin
                next_cycle();
            end
        end
        while (flit_count > ret_count) begin
            pulse_credit();
        end
    endtask

    task automatic test_idle();
        repeat (10) begin
            @(negedge clk);
            check_bit("noc_val", 1'b0, noc_val);
            check_bit("poller_msg_full", 1'b0, poller_msg_full);
        end
        next_cycle();
    endtask

    task automatic test_single();
        poller_msg_t m;
        m = '{flowid: 6'h15, head_ptr: 13'h1abc, len: 12'h5f0,
              dst_x: 4'h7, dst_y: 4'h1, dst_fbits: 4'h9};
        start_write(m);
        @(negedge clk);
        check_bit("noc_val", 1'b0, noc_val);
        next_cycle();
        poller_msg_wr = 1'b0;
        @(negedge clk);
        check_bit("noc_val", 1'b0, noc_val);
        @(negedge clk);
        check_bit("noc_val", 1'b1, noc_val);
        next_cycle();
        drain_and_return();
    endtask

    task automatic test_credit_stall();
        int base;
        base = flit_count;
        repeat (3) write_msg(random_msg());
        repeat (12) next_cycle();
        check_count("flits before credit return", base + 2, flit_count);
        pulse_credit();
        wait (flit_count == base + 3);
        next_cycle();
        drain_and_return();
    endtask

    task automatic test_fill_queue();
        int base;
        base = flit_count;
        // two sent and three queued
        repeat (5) write_msg(random_msg());
        check_bit("poller_msg_full", 1'b0, poller_msg_full);
        write_msg(random_msg());
        check_bit("poller_msg_full", 1'b1, poller_msg_full);
        write_msg(random_msg());
        repeat (4) next_cycle();
        check_count("flits while credits withheld", base + 2, flit_count);
        check_bit("poller_msg_full", 1'b1, poller_msg_full);
        drain_and_return();
        check_bit("poller_msg_full", 1'b0, poller_msg_full);
    endtask

    task automatic test_random_burst();
        int sent;
        sent = 0;
        while (sent < 20) begin
            poller_msg_wr = 1'b0;
            noc_credit_ret = 1'b0;
            if (($random(seed) & 1) != 0 && flit_count > ret_count) begin
                noc_credit_ret = 1'b1;
                ret_count++;
            end
            if (!poller_msg_full) begin
                start_write(random_msg());
                sent++;
            end
            next_cycle();
        end
        poller_msg_wr = 1'b0;
        noc_credit_ret = 1'b0;
        drain_and_return();
    endtask

    initial begin
        rst = 1'b1;
        poller_msg_wr = 1'b0;
        noc_credit_ret = 1'b0;
        {poller_msg_noc_if_flowid, poller_msg_noc_if_head_ptr, poller_msg_noc_if_len,
         poller_msg_noc_if_dst_x, poller_msg_noc_if_dst_y, poller_msg_noc_if_dst_fbits} = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_idle();
        test_single();
        test_credit_stall();
        test_fill_queue();
        test_random_burst();
        if (model_q.size() != 0) begin
            $display("%0d accepted notifications never left as flits", model_q.size());
            errors++;
        end
        $display("%0d errors, %0d flits checked", errors, flit_count);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tcp_rx_msg_noc_if_out.sv */
`timescale 1ns/1ps

module tcp_rx_msg_noc_if_out #(
    parameter int SRC_X       = 0,
    parameter int SRC_Y       = 0,
    parameter int FIFO_DEPTH  = 4,
    parameter int NOC_CREDITS = 2
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        poller_msg_wr,
    input  logic [tcp_rx_msg_pkg::flowid_w-1:0]         poller_msg_noc_if_flowid,
    input  logic [tcp_rx_msg_pkg::rx_payload_ptr_w:0]   poller_msg_noc_if_head_ptr,
    input  logic [tcp_rx_msg_pkg::rx_payload_ptr_w-1:0] poller_msg_noc_if_len,
    input  logic [tcp_rx_msg_pkg::xy_w-1:0]             poller_msg_noc_if_dst_x,
    input  logic [tcp_rx_msg_pkg::xy_w-1:0]             poller_msg_noc_if_dst_y,
    input  logic [tcp_rx_msg_pkg::fbits_w-1:0]          poller_msg_noc_if_dst_fbits,
    input  logic                                        noc_credit_ret,
    output logic                                        poller_msg_full,
    output logic                                        noc_val,
    output logic [tcp_rx_msg_pkg::noc_data_w-1:0]       tcp_rx_ptr_if_noc_data
);

    import tcp_rx_msg_pkg::*;

    poller_msg_t poller_msg_in;
    poller_msg_t fifo_rd_data;
    logic        fifo_empty;
    logic        fifo_rd;
    logic        ctrl_datap_store_inputs;
    logic        credit_avail;

    assign poller_msg_in = '{
        flowid:    poller_msg_noc_if_flowid,
        head_ptr:  poller_msg_noc_if_head_ptr,
        len:       poller_msg_noc_if_len,
        dst_x:     poller_msg_noc_if_dst_x,
        dst_y:     poller_msg_noc_if_dst_y,
        dst_fbits: poller_msg_noc_if_dst_fbits
    };

    tcp_rx_msg_req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) req_fifo_i (
        .clk     (clk),
        .rst     (rst),
        .wr      (poller_msg_wr),
        .wr_data (poller_msg_in),
        .rd      (fifo_rd),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty),
        .full    (poller_msg_full)
    );

    // each send pulse spends one credit
    tcp_rx_noc_credit_cnt #(
        .NOC_CREDITS (NOC_CREDITS)
    ) credit_cnt_i (
        .clk          (clk),
        .rst          (rst),
        .credit_use   (noc_val),
        .credit_ret   (noc_credit_ret),
        .credit_avail (credit_avail)
    );

    tcp_rx_msg_noc_if_out_ctrl ctrl_i (
        .clk                     (clk),
        .rst                     (rst),
        .fifo_empty              (fifo_empty),
        .credit_avail            (credit_avail),
        .fifo_rd                 (fifo_rd),
        .ctrl_datap_store_inputs (ctrl_datap_store_inputs),
        .noc_val                 (noc_val)
    );

    tcp_rx_msg_noc_if_out_datap #(
        .SRC_X (SRC_X),
        .SRC_Y (SRC_Y)
    ) datap_i (
        .clk                     (clk),
        .rst                     (rst),
        .poller_msg              (fifo_rd_data),
        .ctrl_datap_store_inputs (ctrl_datap_store_inputs),
        .tcp_rx_ptr_if_noc_data  (tcp_rx_ptr_if_noc_data)
    );

endmodule

/* tcp_rx_msg_noc_if_out_datap.sv */
`timescale 1ns/1ps

module tcp_rx_msg_noc_if_out_datap #(
    parameter int SRC_X = 0,
    parameter int SRC_Y = 0
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  tcp_rx_msg_pkg::poller_msg_t            poller_msg,
    input  logic                                   ctrl_datap_store_inputs,
    output logic [tcp_rx_msg_pkg::noc_data_w-1:0]  tcp_rx_ptr_if_noc_data
);

    import tcp_rx_msg_pkg::*;

    poller_msg_t     msg_reg;
    poller_msg_t     msg_next;
    tcp_noc_hdr_flit hdr_flit_cast;

    assign tcp_rx_ptr_if_noc_data = hdr_flit_cast;

    always_ff @(posedge clk) begin
        if (rst) begin
            msg_reg <= '0;
        end else begin
            msg_reg <= msg_next;
        end
    end

    // hold the last stored notification between strobes
    always_comb begin
        if (ctrl_datap_store_inputs) begin
            msg_next = poller_msg;
        end else begin
            msg_next = msg_reg;
        end
    end

    always_comb begin
        hdr_flit_cast = '0;

        hdr_flit_cast.core.dst_x_coord = msg_reg.dst_x;
        hdr_flit_cast.core.dst_y_coord = msg_reg.dst_y;
        hdr_flit_cast.core.dst_fbits   = msg_reg.dst_fbits;
        // single header flit with no body
        hdr_flit_cast.core.msg_len     = '0;
        hdr_flit_cast.core.msg_type    = tcp_rx_msg_resp;
        hdr_flit_cast.core.src_x_coord = xy_w'(SRC_X);
        hdr_flit_cast.core.src_y_coord = xy_w'(SRC_Y);
        hdr_flit_cast.core.src_fbits   = tcp_rx_app_ptr_if_fbits;

        hdr_flit_cast.inner.flowid   = msg_reg.flowid;
        hdr_flit_cast.inner.head_ptr = msg_reg.head_ptr;
        hdr_flit_cast.inner.length   = msg_reg.len;
    end

endmodule

/* tcp_rx_msg_noc_if_out_ctrl.sv */
`timescale 1ns/1ps

module tcp_rx_msg_noc_if_out_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic fifo_empty,
    input  logic credit_avail,
    output logic fifo_rd,
    output logic ctrl_datap_store_inputs,
    output logic noc_val
);

    typedef enum logic {
        st_idle,
        st_send
    } state_e;

    state_e state_reg;
    state_e state_next;
    logic   launch;

    // pop only when the network can take the flit
    assign launch = (state_reg == st_idle) & ~fifo_empty & credit_avail;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= st_idle;
        end else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        state_next = state_reg;
        fifo_rd = 1'b0;
        ctrl_datap_store_inputs = 1'b0;
        noc_val = 1'b0;

        case (state_reg)
            st_idle: begin
                if (launch) begin
                    fifo_rd = 1'b1;
                    ctrl_datap_store_inputs = 1'b1;
                    state_next = st_send;
                end
            end
            st_send: begin
                // flit register was loaded on the previous edge
                noc_val = 1'b1;
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

endmodule

/* tcp_rx_noc_credit_cnt.sv */
`timescale 1ns/1ps

module tcp_rx_noc_credit_cnt #(
    parameter int NOC_CREDITS = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic credit_use,
    input  logic credit_ret,
    output logic credit_avail
);

    localparam int cnt_w = $clog2(NOC_CREDITS + 1);
    localparam logic [cnt_w-1:0] max_cnt = cnt_w'(NOC_CREDITS);

    logic [cnt_w-1:0] count;

    assign credit_avail = (count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= max_cnt;
        end else if (credit_use && !credit_ret) begin
            if (count != '0) begin
                count <= count - 1'b1;
            end
        end else if (credit_ret && !credit_use) begin
            // saturate at the network buffer size
            if (count != max_cnt) begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

/* tcp_rx_msg_req_fifo.sv */
`timescale 1ns/1ps

module tcp_rx_msg_req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr,
    input  tcp_rx_msg_pkg::poller_msg_t wr_data,
    input  logic                        rd,
    output tcp_rx_msg_pkg::poller_msg_t rd_data,
    output logic                        empty,
    output logic                        full
);

    import tcp_rx_msg_pkg::*;

    localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int cnt_w = $clog2(FIFO_DEPTH + 1);
    localparam logic [ptr_w-1:0] last_idx = ptr_w'(FIFO_DEPTH - 1);
    localparam logic [cnt_w-1:0] depth_cnt = cnt_w'(FIFO_DEPTH);

    poller_msg_t      mem [FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign empty = (count == '0);
    assign full  = (count == depth_cnt);

    // writes while full are dropped
    assign do_wr = wr & ~full;
    assign do_rd = rd & ~empty;

    // head entry shown with no read latency
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous read and write keeps the count
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* tcp_rx_msg_pkg.sv */
package tcp_rx_msg_pkg;

    localparam int noc_data_w       = 128;
    localparam int xy_w             = 4;
    localparam int fbits_w          = 4;
    localparam int msg_len_w        = 8;
    localparam int msg_type_w       = 8;
    localparam int flowid_w         = 6;
    localparam int rx_payload_ptr_w = 12;

    localparam logic [msg_type_w-1:0] tcp_rx_msg_resp         = 8'h2a;
    localparam logic [fbits_w-1:0]    tcp_rx_app_ptr_if_fbits = 4'h3;

    // poller notification with an extra wrap bit on head_ptr
    typedef struct packed {
        logic [flowid_w-1:0]         flowid;
        logic [rx_payload_ptr_w:0]   head_ptr;
        logic [rx_payload_ptr_w-1:0] len;
        logic [xy_w-1:0]             dst_x;
        logic [xy_w-1:0]             dst_y;
        logic [fbits_w-1:0]          dst_fbits;
    } poller_msg_t;

    typedef struct packed {
        logic [xy_w-1:0]       dst_x_coord;
        logic [xy_w-1:0]       dst_y_coord;
        logic [fbits_w-1:0]    dst_fbits;
        logic [msg_len_w-1:0]  msg_len;
        logic [msg_type_w-1:0] msg_type;
        logic [xy_w-1:0]       src_x_coord;
        logic [xy_w-1:0]       src_y_coord;
        logic [fbits_w-1:0]    src_fbits;
    } noc_hdr_core_t;

    typedef struct packed {
        logic [flowid_w-1:0]         flowid;
        logic [rx_payload_ptr_w:0]   head_ptr;
        logic [rx_payload_ptr_w-1:0] length;
    } noc_hdr_inner_t;

    localparam int hdr_pad_w = noc_data_w - $bits(noc_hdr_core_t) - $bits(noc_hdr_inner_t);

    // padding occupies the top of the flit
    typedef struct packed {
        logic [hdr_pad_w-1:0] padding;
        noc_hdr_inner_t       inner;
        noc_hdr_core_t        core;
    } tcp_noc_hdr_flit;

endpackage
